// File: Makefile
# Verilator build for the FPSCR control shadow unit

SIM      ?= verilator
FLAGS    ?= --binary --timing
TOP      ?= tb_fu_cr2
FILELIST ?= fu_cr2.f
OBJ_DIR  ?= obj_dir
PASS_MSG := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: common/fu_cr2_pkg.sv
// FPSCR control byte types, MSB-first like the architected bit order (bit 24 is index 0)
// only the two control nibbles 6 and 7 are modeled
`default_nettype none

package fu_cr2_pkg;

   // --------------------
   // field types
   // --------------------

   // [0] ve  [1] oe  [2] ue  [3] ze  [4] xe  [5] ni  [6:7] rnd mode
   typedef logic [0:7] fpscr_ctl_t;

   typedef logic [0:3] fpscr_nib_t;    // data or bit mask within a nibble

   // [6] nibble 6 = bits 24..27, [7] nibble 7 = bits 28..31
   typedef logic [6:7] fpscr_nib_sel_t;

   // --------------------
   // stage counts
   // --------------------

   localparam int BYP_DEPTH = 5;    // byp2..byp6
   localparam int CTL_DEPTH = 5;    // ex3..ex7

endpackage

`default_nettype wire

// File: design/fu_cr2.sv
// FPSCR control shadow top level, every stage advances each cycle
// ex1_thread must be one-hot or zero; zero is a bubble
`timescale 1ns/100ps
`default_nettype none

module fu_cr2
   import fu_cr2_pkg::*;
#(
   parameter int NUM_THREADS = 4
) (
   input  wire logic                   nclk,
   input  wire logic                   rst,
   input  wire logic [0:NUM_THREADS-1] ex1_thread,
   input  fpscr_nib_t                  ex1_bit_data,
   input  fpscr_nib_t                  ex1_bit_mask,
   input  fpscr_nib_sel_t              ex1_nib_sel,
   input  wire logic                   ex1_mtfsb,
   input  wire logic                   ex1_mtfsf,
   input  wire logic                   ex1_mtfsfi,
   input  fpscr_ctl_t                  ex2_fpr_byte,      // mtfsf source, one cycle after op
   input  wire logic                   ex7_cancel,
   output fpscr_ctl_t                  ex2_fpscr_shadow,
   output fpscr_ctl_t                  ex6_fpscr_rd_dat,
   output fpscr_ctl_t                  ex7_fpscr_rd_dat
);

   typedef struct packed {
      logic [0:NUM_THREADS-1] thread;
      logic                   mv;
   } stage_t;

   logic [0:NUM_THREADS-1] ex2_thread;
   logic                   ex2_mv;
   stage_t                 ex2_rec;
   stage_t                 ctl_stages [CTL_DEPTH];    // ex3..ex7
   logic [0:NUM_THREADS-1] older_thread [BYP_DEPTH];  // ex2..ex6
   logic [0:BYP_DEPTH-1]   older_mv;
   logic [0:NUM_THREADS-1] ex2_rd_thread;
   logic [0:BYP_DEPTH-1]   ex2_rd_byp;
   fpscr_ctl_t             byp2_din;
   fpscr_ctl_t             byp_stages [BYP_DEPTH];    // byp2..byp6
   fpscr_ctl_t             committed [NUM_THREADS];

   // --------------------
   // ex1 -> ex2
   // --------------------

   fu_cr2_ex2_merge #(.NUM_THREADS(NUM_THREADS)) u_ex2_merge (
      .nclk             (nclk),
      .rst              (rst),
      .ex1_thread       (ex1_thread),
      .ex1_bit_data     (ex1_bit_data),
      .ex1_bit_mask     (ex1_bit_mask),
      .ex1_nib_sel      (ex1_nib_sel),
      .ex1_mtfsb        (ex1_mtfsb),
      .ex1_mtfsf        (ex1_mtfsf),
      .ex1_mtfsfi       (ex1_mtfsfi),
      .ex2_fpr_byte     (ex2_fpr_byte),
      .ex2_rd_thread    (ex2_rd_thread),
      .ex2_rd_byp       (ex2_rd_byp),
      .committed        (committed),
      .byp_stages       (byp_stages),
      .ex2_thread       (ex2_thread),
      .ex2_mv           (ex2_mv),
      .ex2_fpscr_shadow (ex2_fpscr_shadow),
      .byp2_din         (byp2_din)
   );

   // older stage view for the bypass compares
   assign older_thread[0] = ex2_thread;
   assign older_mv[0]     = ex2_mv;
   for (genvar i = 1; i < BYP_DEPTH; i++) begin : g_older
      assign older_thread[i] = ctl_stages[i-1].thread;
      assign older_mv[i]     = ctl_stages[i-1].mv;
   end

   fu_cr2_byp_sel #(.NUM_THREADS(NUM_THREADS)) u_byp_sel (
      .nclk          (nclk),
      .rst           (rst),
      .ex1_thread    (ex1_thread),
      .older_thread  (older_thread),
      .older_mv      (older_mv),
      .ex2_rd_thread (ex2_rd_thread),
      .ex2_rd_byp    (ex2_rd_byp)
   );

   // --------------------
   // ex3..ex7 pipes
   // --------------------

   assign ex2_rec = '{thread: ex2_thread, mv: ex2_mv};

   fu_cr2_stage_pipe #(
      .payload_t (stage_t),
      .DEPTH     (CTL_DEPTH),
      .RST_VAL   ('0)
   ) u_ctl_pipe (
      .nclk   (nclk),
      .rst    (rst),
      .din    (ex2_rec),
      .stages (ctl_stages)
   );

   fu_cr2_stage_pipe #(
      .payload_t (fpscr_ctl_t),
      .DEPTH     (BYP_DEPTH),
      .RST_VAL   ('0)
   ) u_byp_pipe (
      .nclk   (nclk),
      .rst    (rst),
      .din    (byp2_din),
      .stages (byp_stages)
   );

   // --------------------
   // commit and reads
   // --------------------

   fu_cr2_thread_regs #(.NUM_THREADS(NUM_THREADS)) u_thread_regs (
      .nclk             (nclk),
      .rst              (rst),
      .ex6_thread       (ctl_stages[CTL_DEPTH-2].thread),
      .ex7_thread       (ctl_stages[CTL_DEPTH-1].thread),
      .ex7_mv           (ctl_stages[CTL_DEPTH-1].mv),
      .ex7_cancel       (ex7_cancel),
      .byp6             (byp_stages[BYP_DEPTH-1]),
      .committed        (committed),
      .ex6_fpscr_rd_dat (ex6_fpscr_rd_dat),
      .ex7_fpscr_rd_dat (ex7_fpscr_rd_dat)
   );

endmodule

`default_nettype wire

// File: design/fu_cr2_byp_sel.sv
// read select for the ex2 shadow, registered from ex1
// thread vectors are one-hot or zero; a zero vector selects nothing
`timescale 1ns/100ps
`default_nettype none

module fu_cr2_byp_sel
   import fu_cr2_pkg::*;
#(
   parameter int NUM_THREADS = 4
) (
   input  wire logic                   nclk,
   input  wire logic                   rst,
   input  wire logic [0:NUM_THREADS-1] ex1_thread,
   input  wire logic [0:NUM_THREADS-1] older_thread [BYP_DEPTH],  // ex2..ex6
   input  wire logic [0:BYP_DEPTH-1]   older_mv,
   output logic      [0:NUM_THREADS-1] ex2_rd_thread,
   output logic      [0:BYP_DEPTH-1]   ex2_rd_byp
);

   logic [0:BYP_DEPTH-1]   ex1_match;
   logic [0:BYP_DEPTH-1]   ex1_rd_byp;
   logic [0:NUM_THREADS-1] ex1_rd_thread;
   logic                   hit_older;

   // --------------------
   // thread compares
   // --------------------

   for (genvar i = 0; i < BYP_DEPTH; i++) begin : g_match
      // same thread and a move still in flight
      assign ex1_match[i] = (|(ex1_thread & older_thread[i])) & older_mv[i];
   end

   // --------------------
   // priority
   // --------------------

   // ex2 is youngest so it wins over ex3..ex6
   always_comb begin
      hit_older = 1'b0;
      for (int i = 0; i < BYP_DEPTH; i++) begin
         ex1_rd_byp[i] = ex1_match[i] & ~hit_older;
         hit_older     = hit_older | ex1_match[i];
      end
      ex1_rd_thread = ex1_thread & {NUM_THREADS{~hit_older}};  // fall back to committed
   end

   // --------------------
   // ex2 select register
   // --------------------

   always_ff @(posedge nclk) begin
      if (rst) begin
         ex2_rd_thread <= '0;
         ex2_rd_byp    <= '0;
      end else begin
         ex2_rd_thread <= ex1_rd_thread;
         ex2_rd_byp    <= ex1_rd_byp;
      end
   end

endmodule

`default_nettype wire

// File: design/fu_cr2_ex2_merge.sv
// ex2 op register, shadow read mux and control-byte merge
// at most one op flag may be high; ex2_fpr_byte belongs to the op in ex2
`timescale 1ns/100ps
`default_nettype none

module fu_cr2_ex2_merge
   import fu_cr2_pkg::*;
#(
   parameter int NUM_THREADS = 4
) (
   input  wire logic                   nclk,
   input  wire logic                   rst,
   input  wire logic [0:NUM_THREADS-1] ex1_thread,
   input  fpscr_nib_t                  ex1_bit_data,
   input  fpscr_nib_t                  ex1_bit_mask,
   input  fpscr_nib_sel_t              ex1_nib_sel,
   input  wire logic                   ex1_mtfsb,
   input  wire logic                   ex1_mtfsf,
   input  wire logic                   ex1_mtfsfi,
   input  fpscr_ctl_t                  ex2_fpr_byte,
   input  wire logic [0:NUM_THREADS-1] ex2_rd_thread,
   input  wire logic [0:BYP_DEPTH-1]   ex2_rd_byp,
   input  fpscr_ctl_t                  committed [NUM_THREADS],
   input  fpscr_ctl_t                  byp_stages [BYP_DEPTH],
   output logic      [0:NUM_THREADS-1] ex2_thread,
   output logic                        ex2_mv,
   output fpscr_ctl_t                  ex2_fpscr_shadow,
   output fpscr_ctl_t                  byp2_din
);

   logic           ex2_mtfsb;
   logic           ex2_mtfsf;
   logic           ex2_mtfsfi;
   fpscr_nib_t     ex2_bit_data;
   fpscr_nib_t     ex2_bit_mask;
   fpscr_nib_sel_t ex2_nib_sel;
   fpscr_ctl_t     ex2_bit_sel;
   fpscr_ctl_t     ex2_new_data;

   // --------------------
   // ex2 op register
   // --------------------

   always_ff @(posedge nclk) begin
      if (rst) begin
         ex2_thread <= '0;
         ex2_mtfsb  <= 1'b0;
         ex2_mtfsf  <= 1'b0;
         ex2_mtfsfi <= 1'b0;
      end else begin
         ex2_thread <= ex1_thread;
         ex2_mtfsb  <= ex1_mtfsb;
         ex2_mtfsf  <= ex1_mtfsf;
         ex2_mtfsfi <= ex1_mtfsfi;
      end
   end

   always_ff @(posedge nclk) begin
      ex2_bit_data <= ex1_bit_data;
      ex2_bit_mask <= ex1_bit_mask;
      ex2_nib_sel  <= ex1_nib_sel;
   end

   assign ex2_mv = ex2_mtfsb | ex2_mtfsf | ex2_mtfsfi;

   // --------------------
   // shadow read mux
   // --------------------

   // selects are one-hot across threads and bypass stages
   always_comb begin
      ex2_fpscr_shadow = '0;
      for (int i = 0; i < NUM_THREADS; i++) begin
         ex2_fpscr_shadow = ex2_fpscr_shadow | (committed[i] & {8{ex2_rd_thread[i]}});
      end
      for (int i = 0; i < BYP_DEPTH; i++) begin
         ex2_fpscr_shadow = ex2_fpscr_shadow | (byp_stages[i] & {8{ex2_rd_byp[i]}});
      end
   end

   // --------------------
   // write merge
   // --------------------

   assign ex2_bit_sel[0:3] = ex2_bit_mask & {4{ex2_mv & ex2_nib_sel[6]}};
   assign ex2_bit_sel[4:7] = ex2_bit_mask & {4{ex2_mv & ex2_nib_sel[7]}};

   // immediate data is repeated into both nibbles
   assign ex2_new_data = ex2_mtfsf ? ex2_fpr_byte : {ex2_bit_data, ex2_bit_data};

   assign byp2_din = (ex2_fpscr_shadow & ~ex2_bit_sel) |
                     (ex2_new_data & ex2_bit_sel);    // unselected bits keep shadow

endmodule

`default_nettype wire

// File: design/fu_cr2_stage_pipe.sv
// fixed-latency delay line, one register per stage, no stall
// stages[0] is the youngest stage and stages[DEPTH-1] the oldest
`timescale 1ns/100ps
`default_nettype none

module fu_cr2_stage_pipe #(
   parameter type      payload_t = logic,
   parameter int       DEPTH     = 2,
   parameter payload_t RST_VAL   = '0
) (
   input  wire logic nclk,
   input  wire logic rst,
   input  payload_t  din,
   output payload_t  stages [DEPTH]
);

   // --------------------
   // shift register
   // --------------------

   always_ff @(posedge nclk) begin
      if (rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            stages[i] <= RST_VAL;
         end
      end else begin
         stages[0] <= din;                   // youngest stage
         for (int i = 1; i < DEPTH; i++) begin
            stages[i] <= stages[i-1];        // advance every cycle
         end
      end
   end

endmodule

`default_nettype wire

// File: design/fu_cr2_thread_regs.sv
// committed FPSCR control byte per thread, written at the end of ex7
// the ex7 read bypasses byp6 whenever ex7 holds a move, cancelled or not
`timescale 1ns/100ps
`default_nettype none

module fu_cr2_thread_regs
   import fu_cr2_pkg::*;
#(
   parameter int NUM_THREADS = 4
) (
   input  wire logic                   nclk,
   input  wire logic                   rst,
   input  wire logic [0:NUM_THREADS-1] ex6_thread,
   input  wire logic [0:NUM_THREADS-1] ex7_thread,
   input  wire logic                   ex7_mv,
   input  wire logic                   ex7_cancel,
   input  fpscr_ctl_t                  byp6,
   output fpscr_ctl_t                  committed [NUM_THREADS],
   output fpscr_ctl_t                  ex6_fpscr_rd_dat,
   output fpscr_ctl_t                  ex7_fpscr_rd_dat
);

   logic       ex7_wr;
   fpscr_ctl_t ex7_rd_no_byp;

   // --------------------
   // commit
   // --------------------

   assign ex7_wr = ex7_mv & ~ex7_cancel;

   always_ff @(posedge nclk) begin
      if (rst) begin
         for (int i = 0; i < NUM_THREADS; i++) begin
            committed[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NUM_THREADS; i++) begin
            if (ex7_wr && ex7_thread[i]) begin
               committed[i] <= byp6;           // visible to ex1 of the next cycle
            end
         end
      end
   end

   // --------------------
   // mffs read ports
   // --------------------

   always_comb begin
      ex6_fpscr_rd_dat = '0;
      ex7_rd_no_byp    = '0;
      for (int i = 0; i < NUM_THREADS; i++) begin
         ex6_fpscr_rd_dat = ex6_fpscr_rd_dat | (committed[i] & {8{ex6_thread[i]}});
         ex7_rd_no_byp    = ex7_rd_no_byp | (committed[i] & {8{ex7_thread[i]}});
      end
   end

   assign ex7_fpscr_rd_dat = ex7_mv ? byp6 : ex7_rd_no_byp;

endmodule

`default_nettype wire

// File: fu_cr2.f
common/fu_cr2_pkg.sv
design/fu_cr2_stage_pipe.sv
design/fu_cr2_byp_sel.sv
design/fu_cr2_ex2_merge.sv
design/fu_cr2_thread_regs.sv
design/fu_cr2.sv
testbench/tb_fu_cr2.sv

// File: testbench/tb_fu_cr2.sv
// one table row per cycle; ex2_fpr_byte follows its row by 1 cycle, ex7_cancel by 6
// expected values come from a cycle model with a 6-deep queue of in-flight ops
`timescale 1ns/100ps
`default_nettype none

module tb_fu_cr2
   import fu_cr2_pkg::*;
;

   localparam int NT          = 4;
   localparam int OP_NONE     = 0;
   localparam int OP_MTFSB    = 1;
   localparam int OP_MTFSFI   = 2;
   localparam int OP_MTFSF    = 3;
   localparam int DRAIN_LIMIT = 12;    // cycles

   typedef struct packed {
      logic [0:NT-1]  thread;         // zero is a bubble
      int             kind;
      fpscr_nib_t     data;
      fpscr_nib_t     mask;
      fpscr_nib_sel_t sel;
      fpscr_ctl_t     fpr;
      logic           cancel;
   } row_t;

   typedef struct packed {
      logic [0:NT-1] thread;
      logic          mv;
      fpscr_ctl_t    new_byte;
      logic          cancel;
   } flight_t;

   logic           nclk;
   logic           rst;
   logic [0:NT-1]  ex1_thread;
   fpscr_nib_t     ex1_bit_data;
   fpscr_nib_t     ex1_bit_mask;
   fpscr_nib_sel_t ex1_nib_sel;
   logic           ex1_mtfsb;
   logic           ex1_mtfsf;
   logic           ex1_mtfsfi;
   fpscr_ctl_t     ex2_fpr_byte;
   logic           ex7_cancel;
   fpscr_ctl_t     ex2_fpscr_shadow;
   fpscr_ctl_t     ex6_fpscr_rd_dat;
   fpscr_ctl_t     ex7_fpscr_rd_dat;

   row_t           rows [$];
   flight_t        flight [$];         // rows c-7..c-2 at the start of cycle c
   fpscr_ctl_t     model_regs [NT];
   logic [31:0]    rng;

   fu_cr2 #(.NUM_THREADS(NT)) dut0 (
      .nclk             (nclk),
      .rst              (rst),
      .ex1_thread       (ex1_thread),
      .ex1_bit_data     (ex1_bit_data),
      .ex1_bit_mask     (ex1_bit_mask),
      .ex1_nib_sel      (ex1_nib_sel),
      .ex1_mtfsb        (ex1_mtfsb),
      .ex1_mtfsf        (ex1_mtfsf),
      .ex1_mtfsfi       (ex1_mtfsfi),
      .ex2_fpr_byte     (ex2_fpr_byte),
      .ex7_cancel       (ex7_cancel),
      .ex2_fpscr_shadow (ex2_fpscr_shadow),
      .ex6_fpscr_rd_dat (ex6_fpscr_rd_dat),
      .ex7_fpscr_rd_dat (ex7_fpscr_rd_dat)
   );

   always #2 nclk = ~nclk;    // 4 ns period

   // --------------------
   // helpers
   // --------------------

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic add_row(input int t, input int kind, input fpscr_nib_t data,
                          input fpscr_nib_t mask, input fpscr_nib_sel_t sel,
                          input fpscr_ctl_t fpr, input logic cancel);
      row_t r;
      r.thread = '0;
      if (t >= 0) begin
         r.thread[t] = 1'b1;
      end
      r.kind   = (t >= 0) ? kind : OP_NONE;    // bubbles never move
      r.data   = data;
      r.mask   = mask;
      r.sel    = sel;
      r.fpr    = fpr;
      r.cancel = cancel;
      rows.push_back(r);
   endtask

   task automatic add_bubbles(input int n);
      for (int i = 0; i < n; i++) begin
         add_row(-1, OP_NONE, 4'h0, 4'h0, 2'b00, 8'h00, 1'b0);
      end
   endtask

   function automatic row_t get_row(input int idx);
      row_t r;
      r = '0;
      if (idx >= 0 && idx < rows.size()) begin
         r = rows[idx];
      end
      return r;
   endfunction

   function automatic fpscr_ctl_t read_committed(input logic [0:NT-1] thread);
      fpscr_ctl_t v;
      v = '0;
      for (int i = 0; i < NT; i++) begin
         if (thread[i]) begin
            v = v | model_regs[i];
         end
      end
      return v;
   endfunction

   // selected bits take new data, the rest keep the shadow
   function automatic fpscr_ctl_t merge_byte(input row_t r, input fpscr_ctl_t shadow);
      fpscr_ctl_t res;
      logic       hit;
      logic       d;
      res = shadow;
      for (int b = 0; b < 8; b++) begin
         hit = (r.kind != OP_NONE) && r.mask[b % 4] && r.sel[(b < 4) ? 6 : 7];
         d   = (r.kind == OP_MTFSF) ? r.fpr[b] : r.data[b % 4];
         if (hit) begin
            res[b] = d;
         end
      end
      return res;
   endfunction

   task automatic compare(input string name, input fpscr_ctl_t got, input fpscr_ctl_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   // --------------------
   // table build
   // --------------------

   task automatic build_table();
      int t;
      add_bubbles(3);                                               // idle outputs
      add_row(0, OP_MTFSFI, 4'hA, 4'hF, 2'b11, 8'h00, 1'b0);
      add_bubbles(6);
      add_row(0, OP_NONE, 4'h0, 4'h0, 2'b00, 8'h00, 1'b0);           // read back
      add_row(1, OP_NONE, 4'h0, 4'h0, 2'b00, 8'h00, 1'b0);
      add_row(1, OP_MTFSB, 4'hF, 4'b0100, 2'b01, 8'h00, 1'b0);       // ni only
      add_row(2, OP_MTFSF, 4'h0, 4'hF, 2'b10, 8'h5C, 1'b0);
      add_row(3, OP_MTFSF, 4'h0, 4'b1001, 2'b11, 8'hC3, 1'b0);
      add_bubbles(6);
      for (int i = 0; i < NT; i++) begin
         add_row(i, OP_NONE, 4'h0, 4'h0, 2'b00, 8'h00, 1'b0);
      end
      // same-thread moves at distance 1..5, other threads in between
      add_row(3, OP_MTFSFI, 4'h5, 4'hF, 2'b11, 8'h00, 1'b0);
      add_row(3, OP_MTFSB, 4'h0, 4'h2, 2'b10, 8'h00, 1'b0);
      add_row(0, OP_MTFSFI, 4'h3, 4'h1, 2'b01, 8'h00, 1'b0);
      add_row(3, OP_MTFSFI, 4'h9, 4'h3, 2'b01, 8'h00, 1'b0);
      add_row(0, OP_NONE, 4'h0, 4'h0, 2'b00, 8'h00, 1'b0);
      add_row(1, OP_NONE, 4'h0, 4'h0, 2'b00, 8'h00, 1'b0);
      add_row(3, OP_MTFSB, 4'hF, 4'h8, 2'b10, 8'h00, 1'b0);
      add_bubbles(1);
      add_row(2, OP_MTFSFI, 4'h6, 4'hC, 2'b11, 8'h00, 1'b0);
      add_bubbles(1);
      add_row(3, OP_MTFSF, 4'h0, 4'hF, 2'b01, 8'h3C, 1'b0);
      add_bubbles(4);
      add_row(3, OP_MTFSFI, 4'h0, 4'hF, 2'b10, 8'h00, 1'b0);
      add_bubbles(6);
      add_row(3, OP_NONE, 4'h0, 4'h0, 2'b00, 8'h00, 1'b0);
      // cancelled moves, one of them already bypassed
      add_row(2, OP_MTFSFI, 4'hE, 4'hF, 2'b11, 8'h00, 1'b1);
      add_row(2, OP_NONE, 4'h0, 4'h0, 2'b00, 8'h00, 1'b0);
      add_row(2, OP_MTFSB, 4'h1, 4'h1, 2'b01, 8'h00, 1'b0);
      add_row(1, OP_MTFSFI, 4'hF, 4'hF, 2'b11, 8'h00, 1'b1);
      add_bubbles(6);
      add_row(2, OP_NONE, 4'h0, 4'h0, 2'b00, 8'h00, 1'b0);
      add_row(1, OP_NONE, 4'h0, 4'h0, 2'b00, 8'h00, 1'b0);
      // random fill
      for (int i = 0; i < 32; i++) begin
         rng = xorshift(rng);
         t   = int'(rng % (NT + 1));
         add_row((t == NT) ? -1 : t, int'(rng[9:8]), rng[13:10], rng[17:14],
                 rng[19:18], rng[27:20], rng[31:29] == 3'b000);
      end
   endtask

   // --------------------
   // per-cycle drive and check
   // --------------------

   task automatic drive_cycle(input int c);
      row_t r;
      row_t r_fpr;
      row_t r_cancel;
      r        = get_row(c);
      r_fpr    = get_row(c - 1);
      r_cancel = get_row(c - 6);
      ex1_thread   <= r.thread;
      ex1_bit_data <= r.data;
      ex1_bit_mask <= r.mask;
      ex1_nib_sel  <= r.sel;
      ex1_mtfsb    <= (r.kind == OP_MTFSB);
      ex1_mtfsfi   <= (r.kind == OP_MTFSFI);
      ex1_mtfsf    <= (r.kind == OP_MTFSF);
      ex2_fpr_byte <= r_fpr.fpr;
      ex7_cancel   <= r_cancel.cancel;
   endtask

   task automatic check_cycle(input int c);
      flight_t    old;
      flight_t    rec;
      row_t       r;
      row_t       r6;
      fpscr_ctl_t shadow;
      logic       found;
      old = flight.pop_front();                  // row c-7 commits
      if (old.mv && !old.cancel) begin
         for (int i = 0; i < NT; i++) begin
            if (old.thread[i]) begin
               model_regs[i] = old.new_byte;
            end
         end
      end
      r      = get_row(c - 1);                   // now in ex2
      shadow = read_committed(r.thread);
      found  = 1'b0;
      for (int i = flight.size() - 1; i >= 0; i--) begin
         if (!found && flight[i].mv && (|(flight[i].thread & r.thread))) begin
            shadow = flight[i].new_byte;         // youngest older move
            found  = 1'b1;
         end
      end
      compare("ex2_fpscr_shadow", ex2_fpscr_shadow, shadow);
      r6 = get_row(c - 5);
      compare("ex6_fpscr_rd_dat", ex6_fpscr_rd_dat, read_committed(r6.thread));
      compare("ex7_fpscr_rd_dat", ex7_fpscr_rd_dat,
              flight[0].mv ? flight[0].new_byte : read_committed(flight[0].thread));
      rec.thread   = r.thread;
      rec.mv       = (r.kind != OP_NONE);
      rec.new_byte = merge_byte(r, shadow);
      rec.cancel   = r.cancel;
      flight.push_back(rec);
   endtask

   task automatic run_cycle(input int c);
      drive_cycle(c);
      @(negedge nclk);
      check_cycle(c);
      @(posedge nclk);
   endtask

   function automatic logic pipe_busy(input int c);
      row_t r;
      logic busy;
      r    = get_row(c - 1);
      busy = (|r.thread) || (r.kind != OP_NONE);
      foreach (flight[i]) begin
         busy = busy || (|flight[i].thread) || flight[i].mv;
      end
      return busy;
   endfunction

   // --------------------
   // main sequence
   // --------------------

   initial begin
      int c;
      int guard;
      nclk         = 1'b0;
      rst          = 1'b1;
      ex1_thread   = '0;
      ex1_bit_data = '0;
      ex1_bit_mask = '0;
      ex1_nib_sel  = '0;
      ex1_mtfsb    = 1'b0;
      ex1_mtfsf    = 1'b0;
      ex1_mtfsfi   = 1'b0;
      ex2_fpr_byte = '0;
      ex7_cancel   = 1'b0;
      rng          = 32'h6537_e96b;
      for (int i = 0; i < NT; i++) begin
         model_regs[i] = '0;
      end
      for (int i = 0; i < 6; i++) begin
         flight.push_back('0);                   // reset leaves the pipe empty
      end
      build_table();
      repeat (3) @(posedge nclk);
      rst <= 1'b0;
      c = 0;
      while (c < rows.size()) begin
         run_cycle(c);
         c++;
      end
      guard = 0;
      while (pipe_busy(c) && guard < DRAIN_LIMIT) begin
         run_cycle(c);
         c++;
         guard++;
      end
      if (pipe_busy(c)) begin
         $display("pipeline did not drain within %0d cycles", DRAIN_LIMIT);
         $display("Test failed");
         $fatal(1);
      end else begin
         $display("Test completed successfully");
         $finish;
      end
   end

endmodule

`default_nettype wire
